//--- pcs_rx_pkg.sv
// PCS receive package
// Block and XGMII structs, control codes, block types and lock thresholds
package pcs_rx_pkg;

    // 66-bit block as received with the header in the top two bits
    typedef struct packed {
        logic [1:0]  hdr;
        logic [63:0] payload;   // Type byte in 63:56 for control blocks
    } rx_block_t;

    // Lane 0 is data[63:56] and ctl[7]
    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  ctl;
    } xgmii64_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  ctl;
    } xgmii32_t;

    // XGMII control characters
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hfb;
    localparam logic [7:0] XGMII_TERM  = 8'hfd;
    localparam logic [7:0] XGMII_ERROR = 8'hfe;

    // Sync headers
    localparam logic [1:0] HDR_DATA = 2'b01;
    localparam logic [1:0] HDR_CTRL = 2'b10;

    // Block type field
    localparam logic [7:0] BT_IDLE   = 8'h1e;
    localparam logic [7:0] BT_START4 = 8'h33;
    localparam logic [7:0] BT_START0 = 8'h78;
    localparam logic [7:0] BT_TERM0  = 8'h87;   // Digit is data bytes before terminate
    localparam logic [7:0] BT_TERM1  = 8'h99;
    localparam logic [7:0] BT_TERM2  = 8'haa;
    localparam logic [7:0] BT_TERM3  = 8'hb4;
    localparam logic [7:0] BT_TERM4  = 8'hcc;
    localparam logic [7:0] BT_TERM5  = 8'hd2;
    localparam logic [7:0] BT_TERM6  = 8'he1;
    localparam logic [7:0] BT_TERM7  = 8'hff;

    // Block lock thresholds
    localparam int LOCK_GOOD_CNT = 32;  // Consecutive good headers to lock
    localparam int LOCK_BAD_MAX  = 8;   // Bad headers per window to drop lock
    localparam int LOCK_WINDOW   = 64;  // Window length in blocks

    typedef logic [$clog2(LOCK_GOOD_CNT)-1:0] good_cnt_t;
    typedef logic [$clog2(LOCK_BAD_MAX)-1:0]  bad_cnt_t;
    typedef logic [$clog2(LOCK_WINDOW)-1:0]   win_cnt_t;

    // Descrambler taps of x^58 + x^39 + 1
    localparam int SCR_TAP_A = 58;
    localparam int SCR_TAP_B = 39;

endpackage

//--- pcs_rx_block_lock.sv
// Block lock stage
// Checks sync headers, tracks lock state and registers each block
`timescale 1ns/10ps

module pcs_rx_block_lock (
    input  logic                  i_rxc,
    input  logic                  i_rst_n,
    input  pcs_rx_pkg::rx_block_t i_blk,
    input  logic                  i_blk_valid,
    output pcs_rx_pkg::rx_block_t o_blk,
    output logic                  o_blk_valid,
    output logic                  o_hdr_ok,
    output logic                  o_lock
);

    pcs_rx_pkg::good_cnt_t good_cnt;
    pcs_rx_pkg::bad_cnt_t  bad_cnt;
    pcs_rx_pkg::win_cnt_t  win_cnt;
    logic                  hdr_good;

    // Only 01 and 10 are legal headers
    assign hdr_good = (i_blk.hdr == pcs_rx_pkg::HDR_DATA) ||
                      (i_blk.hdr == pcs_rx_pkg::HDR_CTRL);

    always_ff @(posedge i_rxc or negedge i_rst_n) begin
        if (!i_rst_n) begin
            good_cnt    <= '0;
            bad_cnt     <= '0;
            win_cnt     <= '0;
            o_lock      <= 1'b0;
            o_hdr_ok    <= 1'b0;
            o_blk_valid <= 1'b0;
        end else begin
            o_blk_valid <= i_blk_valid;
            if (i_blk_valid) begin
                o_hdr_ok <= hdr_good;
                if (!o_lock) begin
                    if (!hdr_good) begin
                        good_cnt <= '0;     // Run of good headers broken
                    end else if (good_cnt ==
                                 pcs_rx_pkg::good_cnt_t'(pcs_rx_pkg::LOCK_GOOD_CNT - 1)) begin
                        o_lock   <= 1'b1;
                        good_cnt <= '0;
                        bad_cnt  <= '0;
                        win_cnt  <= '0;
                    end else begin
                        good_cnt <= good_cnt + 1'b1;
                    end
                end else begin
                    if (!hdr_good &&
                        bad_cnt == pcs_rx_pkg::bad_cnt_t'(pcs_rx_pkg::LOCK_BAD_MAX - 1)) begin
                        o_lock   <= 1'b0;   // Too many bad headers in window
                        good_cnt <= '0;
                        bad_cnt  <= '0;
                        win_cnt  <= '0;
                    end else if (win_cnt ==
                                 pcs_rx_pkg::win_cnt_t'(pcs_rx_pkg::LOCK_WINDOW - 1)) begin
                        win_cnt <= '0;      // New window
                        bad_cnt <= '0;
                    end else begin
                        win_cnt <= win_cnt + 1'b1;
                        if (!hdr_good) begin
                            bad_cnt <= bad_cnt + 1'b1;
                        end
                    end
                end
            end
        end
    end

    // Block register loads on each valid block
    always_ff @(posedge i_rxc) begin
        if (i_blk_valid) begin
            o_blk <= i_blk;
        end
    end

    // Lock is only ever gained on a block with a good header
    a_lock_rise_good_hdr: assert property (
        @(posedge i_rxc) disable iff (!i_rst_n)
        $rose(o_lock) |-> (o_blk_valid && o_hdr_ok)
    );

endmodule

//--- pcs_rx_descrambler.sv
// Self-synchronising descrambler for x^58 + x^39 + 1
// Descrambles the payload of each valid block and passes the header through
`timescale 1ns/10ps

module pcs_rx_descrambler (
    input  logic                  i_rxc,
    input  logic                  i_rst_n,
    input  pcs_rx_pkg::rx_block_t i_blk,
    input  logic                  i_blk_valid,
    input  logic                  i_hdr_ok,
    input  logic                  i_lock,
    output pcs_rx_pkg::rx_block_t o_blk,
    output logic                  o_blk_valid,
    output logic                  o_hdr_ok,
    output logic                  o_lock
);

    logic [pcs_rx_pkg::SCR_TAP_A-1:0] scr_q;
    logic [pcs_rx_pkg::SCR_TAP_A-1:0] scr_nxt;
    logic [63:0]                      plain;

    // Bit 0 of the state holds the most recent received bit
    always_comb begin
        scr_nxt = scr_q;
        for (int b = 63; b >= 0; b--) begin
            plain[b] = i_blk.payload[b] ^ scr_nxt[pcs_rx_pkg::SCR_TAP_A-1] ^
                       scr_nxt[pcs_rx_pkg::SCR_TAP_B-1];
            scr_nxt  = {scr_nxt[pcs_rx_pkg::SCR_TAP_A-2:0], i_blk.payload[b]};
        end
    end

    always_ff @(posedge i_rxc or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scr_q       <= '0;
            o_blk_valid <= 1'b0;
            o_hdr_ok    <= 1'b0;
            o_lock      <= 1'b0;
        end else begin
            o_blk_valid <= i_blk_valid;
            if (i_blk_valid) begin
                scr_q    <= scr_nxt;    // Shifts in scrambled bits
                o_hdr_ok <= i_hdr_ok;
                o_lock   <= i_lock;
            end
        end
    end

    always_ff @(posedge i_rxc) begin
        if (i_blk_valid) begin
            o_blk.hdr     <= i_blk.hdr;
            o_blk.payload <= plain;
        end
    end

endmodule

//--- pcs_rx_block_decode.sv
// 64b/66b block decoder
// Turns a descrambled block into XGMII data and control, or error characters
`timescale 1ns/10ps

module pcs_rx_block_decode (
    input  logic                  i_rxc,
    input  logic                  i_rst_n,
    input  pcs_rx_pkg::rx_block_t i_blk,
    input  logic                  i_blk_valid,
    input  logic                  i_hdr_ok,
    input  logic                  i_lock,
    output pcs_rx_pkg::xgmii64_t  o_word,
    output logic                  o_word_valid
);

    logic [7:0]           blk_type;
    logic                 is_term;
    logic [2:0]           term_k;
    logic [63:0]          term_data;
    pcs_rx_pkg::xgmii64_t dec;

    assign blk_type  = i_blk.payload[63:56];
    assign term_data = {i_blk.payload[55:0], 8'h00};    // Data bytes moved up to lane 0

    // Terminate types and their data byte count
    always_comb begin
        is_term = 1'b1;
        term_k  = 3'd0;
        case (blk_type)
            pcs_rx_pkg::BT_TERM0: term_k = 3'd0;
            pcs_rx_pkg::BT_TERM1: term_k = 3'd1;
            pcs_rx_pkg::BT_TERM2: term_k = 3'd2;
            pcs_rx_pkg::BT_TERM3: term_k = 3'd3;
            pcs_rx_pkg::BT_TERM4: term_k = 3'd4;
            pcs_rx_pkg::BT_TERM5: term_k = 3'd5;
            pcs_rx_pkg::BT_TERM6: term_k = 3'd6;
            pcs_rx_pkg::BT_TERM7: term_k = 3'd7;
            default:              is_term = 1'b0;
        endcase
    end

    always_comb begin
        // Errors unless a legal block arrives while locked
        dec.data = {8{pcs_rx_pkg::XGMII_ERROR}};
        dec.ctl  = 8'hff;
        if (i_lock && i_hdr_ok) begin
            if (i_blk.hdr == pcs_rx_pkg::HDR_DATA) begin
                dec.data = i_blk.payload;
                dec.ctl  = 8'h00;
            end else if (blk_type == pcs_rx_pkg::BT_IDLE) begin
                dec.data = {8{pcs_rx_pkg::XGMII_IDLE}};
            end else if (blk_type == pcs_rx_pkg::BT_START0) begin
                dec.data = {pcs_rx_pkg::XGMII_START, i_blk.payload[55:0]};
                dec.ctl  = 8'h80;
            end else if (blk_type == pcs_rx_pkg::BT_START4) begin
                dec.data = {{4{pcs_rx_pkg::XGMII_IDLE}}, pcs_rx_pkg::XGMII_START,
                            i_blk.payload[23:0]};
                dec.ctl  = 8'hf8;
            end else if (is_term) begin
                dec.ctl = 8'hff >> term_k;  // Control from lane k on
                for (int l = 0; l < 8; l++) begin
                    if (l < int'(term_k)) begin
                        dec.data[63-8*l -: 8] = term_data[63-8*l -: 8];
                    end else if (l == int'(term_k)) begin
                        dec.data[63-8*l -: 8] = pcs_rx_pkg::XGMII_TERM;
                    end else begin
                        dec.data[63-8*l -: 8] = pcs_rx_pkg::XGMII_IDLE;
                    end
                end
            end
        end
    end

    always_ff @(posedge i_rxc or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_word_valid <= 1'b0;
        end else begin
            o_word_valid <= i_blk_valid;
        end
    end

    always_ff @(posedge i_rxc) begin
        if (i_blk_valid) begin
            o_word <= dec;
        end
    end

    function automatic logic is_ctl_char(input logic [7:0] c);
        return c inside {pcs_rx_pkg::XGMII_IDLE, pcs_rx_pkg::XGMII_START,
                         pcs_rx_pkg::XGMII_TERM, pcs_rx_pkg::XGMII_ERROR};
    endfunction

    // A flagged lane always carries a control character
    for (genvar l = 0; l < 8; l++) begin : g_lane_chk
        a_ctl_lane: assert property (
            @(posedge i_rxc) disable iff (!i_rst_n)
            (o_word_valid && o_word.ctl[7-l]) |-> is_ctl_char(o_word.data[63-8*l -: 8])
        );
    end

endmodule

//--- pcs_rx_width_split.sv
// 64 to 32 bit XGMII width splitter
// Sends the upper half of each word, then the lower half on the next cycle
`timescale 1ns/10ps

module pcs_rx_width_split (
    input  logic                 i_rxc,
    input  logic                 i_rst_n,
    input  pcs_rx_pkg::xgmii64_t i_word,
    input  logic                 i_word_valid,
    output pcs_rx_pkg::xgmii32_t o_rxd,
    output logic                 o_rx_valid
);

    pcs_rx_pkg::xgmii32_t lo_q;     // Lower half waiting for its turn
    logic                 phase;

    always_ff @(posedge i_rxc or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase      <= 1'b0;
            o_rx_valid <= 1'b0;
        end else begin
            if (i_word_valid) begin
                phase      <= 1'b1;
                o_rx_valid <= 1'b1;
            end else if (phase) begin
                phase      <= 1'b0;
                o_rx_valid <= 1'b1;
            end else begin
                o_rx_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_rxc) begin
        if (i_word_valid) begin
            o_rxd <= {i_word.data[63:32], i_word.ctl[7:4]};
            lo_q  <= {i_word.data[31:0], i_word.ctl[3:0]};
        end else if (phase) begin
            o_rxd <= lo_q;
        end
    end

    // Two halves per word need an idle cycle between strobes
    a_no_back_to_back: assert property (
        @(posedge i_rxc) disable iff (!i_rst_n)
        i_word_valid |=> !i_word_valid
    );

endmodule

//--- pcs_rx_top.sv
// PCS receive top level
// Block lock, descrambler, decoder and width splitter in a chain
`timescale 1ns/10ps

module pcs_rx_top (
    input  logic                  i_rxc,
    input  logic                  i_rst_n,
    input  pcs_rx_pkg::rx_block_t i_rxd,
    input  logic                  i_rx_valid,
    output pcs_rx_pkg::xgmii32_t  o_rxd,
    output logic                  o_rx_valid,
    output logic                  o_block_lock
);

    pcs_rx_pkg::rx_block_t lk_blk;
    logic                  lk_valid;
    logic                  lk_hdr_ok;
    pcs_rx_pkg::rx_block_t ds_blk;
    logic                  ds_valid;
    logic                  ds_hdr_ok;
    logic                  ds_lock;
    pcs_rx_pkg::xgmii64_t  word;
    logic                  word_valid;

    pcs_rx_block_lock u_block_lock (
        .i_rxc       (i_rxc),
        .i_rst_n     (i_rst_n),
        .i_blk       (i_rxd),
        .i_blk_valid (i_rx_valid),
        .o_blk       (lk_blk),
        .o_blk_valid (lk_valid),
        .o_hdr_ok    (lk_hdr_ok),
        .o_lock      (o_block_lock)
    );

    pcs_rx_descrambler u_descrambler (
        .i_rxc       (i_rxc),
        .i_rst_n     (i_rst_n),
        .i_blk       (lk_blk),
        .i_blk_valid (lk_valid),
        .i_hdr_ok    (lk_hdr_ok),
        .i_lock      (o_block_lock),
        .o_blk       (ds_blk),
        .o_blk_valid (ds_valid),
        .o_hdr_ok    (ds_hdr_ok),
        .o_lock      (ds_lock)
    );

    pcs_rx_block_decode u_block_decode (
        .i_rxc        (i_rxc),
        .i_rst_n      (i_rst_n),
        .i_blk        (ds_blk),
        .i_blk_valid  (ds_valid),
        .i_hdr_ok     (ds_hdr_ok),
        .i_lock       (ds_lock),
        .o_word       (word),
        .o_word_valid (word_valid)
    );

    pcs_rx_width_split u_width_split (
        .i_rxc        (i_rxc),
        .i_rst_n      (i_rst_n),
        .i_word       (word),
        .i_word_valid (word_valid),
        .o_rxd        (o_rxd),
        .o_rx_valid   (o_rx_valid)
    );

endmodule

//--- tb_pcs_rx.sv
// Testbench for the PCS receive path
// Scrambling encoder model feeds the DUT and assertions check words against a queue
`timescale 1ns/10ps

module tb_pcs_rx;

    logic                  i_rxc;
    logic                  i_rst_n;
    pcs_rx_pkg::rx_block_t i_rxd;
    logic                  i_rx_valid;
    pcs_rx_pkg::xgmii32_t  o_rxd;
    logic                  o_rx_valid;
    logic                  o_block_lock;

    pcs_rx_pkg::xgmii32_t exp_q[$];     // Expected 32-bit words, upper half first
    pcs_rx_pkg::xgmii32_t exp_cur;
    logic                 have_exp;
    logic                 consumed;
    logic [4:0]           vld_pipe;
    logic [57:0]          scr_st;       // Encoder scrambler, newest bit in 0
    logic                 lock_st;      // Lock model after the last block sent
    logic                 exp_lock;
    logic [63:0]          rnd;
    int                   good_run;
    int                   bad_cnt;
    int                   win_cnt;
    integer               seed;
    int                   word_errs;
    int                   lock_errs;
    int                   timing_errs;
    int                   timeout_errs;
    int                   n;

    pcs_rx_top u_dut (
        .i_rxc        (i_rxc),
        .i_rst_n      (i_rst_n),
        .i_rxd        (i_rxd),
        .i_rx_valid   (i_rx_valid),
        .o_rxd        (o_rxd),
        .o_rx_valid   (o_rx_valid),
        .o_block_lock (o_block_lock)
    );

    initial begin
        i_rxc = 1'b0;
        forever #5 i_rxc = ~i_rxc;
    end

    function automatic logic [7:0] term_type(input int k);
        case (k)
            0:       return pcs_rx_pkg::BT_TERM0;
            1:       return pcs_rx_pkg::BT_TERM1;
            2:       return pcs_rx_pkg::BT_TERM2;
            3:       return pcs_rx_pkg::BT_TERM3;
            4:       return pcs_rx_pkg::BT_TERM4;
            5:       return pcs_rx_pkg::BT_TERM5;
            6:       return pcs_rx_pkg::BT_TERM6;
            default: return pcs_rx_pkg::BT_TERM7;
        endcase
    endfunction

    // Decoder rules applied to the plain payload
    function automatic pcs_rx_pkg::xgmii64_t expected_word(input logic [1:0] hdr,
                                                           input logic [63:0] p,
                                                           input logic locked);
        pcs_rx_pkg::xgmii64_t w;
        int                   k;
        w.data = {8{pcs_rx_pkg::XGMII_ERROR}};
        w.ctl  = 8'hff;
        k      = -1;
        for (int i = 0; i < 8; i++) begin
            if (p[63:56] == term_type(i)) k = i;
        end
        if (!locked || !(hdr == pcs_rx_pkg::HDR_DATA || hdr == pcs_rx_pkg::HDR_CTRL)) begin
            return w;
        end
        if (hdr == pcs_rx_pkg::HDR_DATA) begin
            w.data = p;
            w.ctl  = 8'h00;
        end else if (p[63:56] == pcs_rx_pkg::BT_IDLE) begin
            w.data = {8{pcs_rx_pkg::XGMII_IDLE}};
        end else if (p[63:56] == pcs_rx_pkg::BT_START0) begin
            w.data = {pcs_rx_pkg::XGMII_START, p[55:0]};
            w.ctl  = 8'h80;
        end else if (p[63:56] == pcs_rx_pkg::BT_START4) begin
            w.data = {{4{pcs_rx_pkg::XGMII_IDLE}}, pcs_rx_pkg::XGMII_START, p[23:0]};
            w.ctl  = 8'hf8;
        end else if (k >= 0) begin
            for (int l = 0; l < 8; l++) begin
                if (l < k) begin
                    w.data[63-8*l -: 8] = p[55-8*l -: 8];  // Data bytes follow the type byte
                    w.ctl[7-l]          = 1'b0;
                end else if (l == k) begin
                    w.data[63-8*l -: 8] = pcs_rx_pkg::XGMII_TERM;
                end else begin
                    w.data[63-8*l -: 8] = pcs_rx_pkg::XGMII_IDLE;
                end
            end
        end
        return w;
    endfunction

    function automatic void update_lock(input logic good);
        if (!lock_st) begin
            good_run = good ? good_run + 1 : 0;
            if (good_run == pcs_rx_pkg::LOCK_GOOD_CNT) begin
                lock_st  = 1'b1;
                good_run = 0;
                bad_cnt  = 0;
                win_cnt  = 0;
            end
        end else begin
            if (!good) bad_cnt++;
            win_cnt++;
            if (bad_cnt == pcs_rx_pkg::LOCK_BAD_MAX) begin
                lock_st  = 1'b0;
                good_run = 0;
                bad_cnt  = 0;
                win_cnt  = 0;
            end else if (win_cnt == pcs_rx_pkg::LOCK_WINDOW) begin
                win_cnt = 0;    // Bad count starts again with each window
                bad_cnt = 0;
            end
        end
    endfunction

    // Scramble, queue the expected halves and drive one block with an idle cycle after it
    task automatic send_block(input logic [1:0] hdr, input logic [63:0] plain);
        pcs_rx_pkg::xgmii64_t w;
        logic [63:0]          scr;
        for (int b = 63; b >= 0; b--) begin
            scr[b] = plain[b] ^ scr_st[57] ^ scr_st[38];
            scr_st = {scr_st[56:0], scr[b]};
        end
        update_lock(hdr == pcs_rx_pkg::HDR_DATA || hdr == pcs_rx_pkg::HDR_CTRL);
        w = expected_word(hdr, plain, lock_st);
        exp_q.push_back({w.data[63:32], w.ctl[7:4]});
        exp_q.push_back({w.data[31:0], w.ctl[3:0]});
        i_rxd      = {hdr, scr};
        i_rx_valid = 1'b1;
        @(negedge i_rxc);
        i_rx_valid = 1'b0;
        exp_lock   = lock_st;   // Lock register now holds the result of this block
        @(negedge i_rxc);
    endtask

    always @(posedge i_rxc) begin
        if (!i_rst_n) begin
            consumed <= 1'b0;
            vld_pipe <= '0;
        end else begin
            consumed <= o_rx_valid;
            vld_pipe <= {vld_pipe[3:0], i_rx_valid};
        end
    end

    // Retire the word checked at the last rising edge
    always @(negedge i_rxc) begin
        if (consumed && exp_q.size() > 0) exp_q.delete(0);
        have_exp = (exp_q.size() > 0);
        if (have_exp) exp_cur = exp_q[0];
    end

    a_word_present: assert property (@(posedge i_rxc) disable iff (!i_rst_n)
        o_rx_valid |-> have_exp)
        else begin
            word_errs++;
            $display("Output word at %0t arrived with no word expected", $time);
        end

    a_word_value: assert property (@(posedge i_rxc) disable iff (!i_rst_n)
        (o_rx_valid && have_exp) |-> (o_rxd == exp_cur))
        else begin
            word_errs++;
            $display("CHECK FAILED t=%0t o_rxd exp=%h act=%h",
                     $time, $sampled(exp_cur), $sampled(o_rxd));
        end

    // Upper half four edges after the input strobe and lower half five
    a_word_timing: assert property (@(posedge i_rxc) disable iff (!i_rst_n)
        o_rx_valid == (vld_pipe[3] | vld_pipe[4]))
        else begin
            timing_errs++;
            $display("CHECK FAILED t=%0t o_rx_valid exp=%b act=%b", $time,
                     $sampled(vld_pipe[3] | vld_pipe[4]), $sampled(o_rx_valid));
        end

    a_lock_state: assert property (@(posedge i_rxc) disable iff (!i_rst_n)
        o_block_lock == exp_lock)
        else begin
            lock_errs++;
            $display("CHECK FAILED t=%0t o_block_lock exp=%b act=%b",
                     $time, $sampled(exp_lock), $sampled(o_block_lock));
        end

    initial begin
        seed         = 97193;
        i_rst_n      = 1'b0;
        i_rxd        = '0;
        i_rx_valid   = 1'b0;
        exp_cur      = '0;
        have_exp     = 1'b0;
        scr_st       = '0;
        lock_st      = 1'b0;
        exp_lock     = 1'b0;
        good_run     = 0;
        bad_cnt      = 0;
        win_cnt      = 0;
        word_errs    = 0;
        lock_errs    = 0;
        timing_errs  = 0;
        timeout_errs = 0;
        repeat (5) @(posedge i_rxc);
        @(negedge i_rxc);
        i_rst_n = 1'b1;

        // Lock comes with the 32nd good header
        repeat (32) send_block(pcs_rx_pkg::HDR_CTRL, {pcs_rx_pkg::BT_IDLE, 56'h0});
        repeat (8) send_block(pcs_rx_pkg::HDR_DATA, {$random(seed), $random(seed)});

        send_block(pcs_rx_pkg::HDR_CTRL, {pcs_rx_pkg::BT_IDLE, 56'h0});
        rnd = {$random(seed), $random(seed)};
        send_block(pcs_rx_pkg::HDR_CTRL, {pcs_rx_pkg::BT_START0, rnd[55:0]});
        send_block(pcs_rx_pkg::HDR_CTRL, {pcs_rx_pkg::BT_START4, 32'h0, rnd[23:0]});
        for (n = 0; n < 8; n++) begin
            rnd = {$random(seed), $random(seed)};
            send_block(pcs_rx_pkg::HDR_CTRL, {term_type(n), rnd[55:0]});
        end

        // Single errors while lock holds
        rnd = {$random(seed), $random(seed)};
        send_block(pcs_rx_pkg::HDR_CTRL, {8'h55, rnd[55:0]});
        send_block(pcs_rx_pkg::HDR_DATA, rnd);
        send_block(2'b00, rnd);
        send_block(pcs_rx_pkg::HDR_DATA, rnd);
        send_block(2'b11, rnd);
        send_block(pcs_rx_pkg::HDR_DATA, rnd);

        // Idle until a fresh window starts
        for (n = 0; n < 64 && win_cnt != 0; n++) begin
            send_block(pcs_rx_pkg::HDR_CTRL, {pcs_rx_pkg::BT_IDLE, 56'h0});
        end
        for (n = 0; n < 8; n++) begin
            rnd = {$random(seed), $random(seed)};
            send_block(n[0] ? 2'b11 : 2'b00, rnd);
            send_block(pcs_rx_pkg::HDR_DATA, rnd);
        end
        repeat (36) send_block(pcs_rx_pkg::HDR_DATA, {$random(seed), $random(seed)});

        for (n = 0; n < 40 && exp_q.size() != 0; n++) @(negedge i_rxc);
        if (exp_q.size() != 0) begin
            timeout_errs++;
            $display("Timeout with %0d expected words never seen at the output", exp_q.size());
        end

        $display("Errors: word %0d, lock %0d, timing %0d, timeout %0d",
                 word_errs, lock_errs, timing_errs, timeout_errs);
        if (word_errs + lock_errs + timing_errs + timeout_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
pcs_rx_pkg.sv
pcs_rx_block_lock.sv
pcs_rx_descrambler.sv
pcs_rx_block_decode.sv
pcs_rx_width_split.sv
pcs_rx_top.sv
tb_pcs_rx.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_pcs_rx \
		-Mdir obj_dir -f sim.f

run: compile
	./obj_dir/Vtb_pcs_rx > sim.log 2>&1 || true
	cat sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q ">>> PASS" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
